// ==== Makefile ====
# Verilator build and run for the iterative multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_imul_iter
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Test completed successfully

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/imul_iter.sv ====
/*
  iterative signed 32x32 multiplier top level,
  datapath and control FSM joined behind val/rdy ports
*/

`timescale 1ns/1ns

module imul_iter (
  input  logic               clk,
  input  logic               reset,

  // request side
  input  imul_pkg::operand_t req_a,
  input  imul_pkg::operand_t req_b,
  input  logic               req_val,
  output logic               req_rdy,

  // response side
  output imul_pkg::product_t resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // --------------------------------------------------
  // control to datapath
  // --------------------------------------------------

  logic load;
  logic step;
  logic fix_sign;

  // datapath to control
  logic count_zero;

  // registers, shift-and-add, sign fix
  imul_iter_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .step        (step),
    .fix_sign    (fix_sign),
    .count_zero  (count_zero),
    .resp_result (resp_result)
  );

  // handshakes and sequencing
  imul_iter_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .count_zero (count_zero),
    .load       (load),
    .step       (step),
    .fix_sign   (fix_sign)
  );

endmodule

// ==== src/imul_iter_ctrl.sv ====
/*
  multiplier control FSM: request and response handshakes
  and per-cycle steering of the datapath
*/

`timescale 1ns/1ns

module imul_iter_ctrl (
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // datapath status
  input  logic count_zero,

  // datapath steering
  output logic load,
  output logic step,
  output logic fix_sign
);

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  imul_pkg::mul_state_e state_reg;
  imul_pkg::mul_state_e state_next;

  // handshake events on the coming edge
  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= imul_pkg::st_idle;
    end else begin
      state_reg <= state_next;
    end
  end

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      imul_pkg::st_idle: begin
        // accept edge starts the iteration
        if (req_go) begin
          state_next = imul_pkg::st_calc;
        end
      end
      imul_pkg::st_calc: begin
        // counter at zero means this is the 32nd step
        if (count_zero) begin
          state_next = imul_pkg::st_sign;
        end
      end
      imul_pkg::st_sign: begin
        // single unconditional correction cycle
        state_next = imul_pkg::st_done;
      end
      imul_pkg::st_done: begin
        // hold the result until the consumer takes it
        if (resp_go) begin
          state_next = imul_pkg::st_idle;
        end
      end
      default: begin
        state_next = imul_pkg::st_idle;
      end
    endcase
  end

  // --------------------------------------------------
  // output decode
  // --------------------------------------------------

  // only idle takes requests and only done offers a response
  assign req_rdy  = (state_reg == imul_pkg::st_idle);
  assign resp_val = (state_reg == imul_pkg::st_done);

  // load rides on the accept edge itself
  assign load     = (state_reg == imul_pkg::st_idle) && req_val;

  // one step per calc cycle, including the cycle that sees count_zero
  assign step     = (state_reg == imul_pkg::st_calc);

  assign fix_sign = (state_reg == imul_pkg::st_sign);

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // one multiplication in flight, the request side reopens only after a hand-off
  a_rdy_after_handoff: assert property (
    @(posedge clk) disable iff (reset)
    $rose(req_rdy) |-> $past(resp_go)
  ) else $error("req_rdy rose without a preceding response hand-off");

  // a pending response is not withdrawn under back-pressure
  a_resp_val_held: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val
  ) else $error("resp_val dropped before resp_rdy was seen");

endmodule

// ==== src/imul_iter_dpath.sv ====
/*
  multiplier datapath: operand magnitudes, shift registers,
  partial-product accumulation, iteration counter and sign fix
*/

`timescale 1ns/1ns

module imul_iter_dpath (
  input  logic               clk,
  input  logic               reset,

  // request operands, sampled on load
  input  imul_pkg::operand_t req_a,
  input  imul_pkg::operand_t req_b,

  // steering from control
  input  logic               load,
  input  logic               step,
  input  logic               fix_sign,

  // status back to control
  output logic               count_zero,

  // partial sum register, final product once in done
  output imul_pkg::product_t resp_result
);

  // --------------------------------------------------
  // registers
  // --------------------------------------------------

  // multiplicand, zero-extended and shifted left each step
  imul_pkg::product_t a_reg;

  // multiplier magnitude, shifted right each step
  imul_pkg::operand_t b_reg;

  // running partial sum
  imul_pkg::product_t sum_reg;

  // operand signs captured at load
  logic               sign_a_reg;
  logic               sign_b_reg;

  // remaining steps after the current one
  imul_pkg::count_t   count_reg;

  // --------------------------------------------------
  // combinational helpers
  // --------------------------------------------------

  // two's complement magnitude of each request operand
  // most negative input maps to 2^31, still correct as unsigned
  imul_pkg::operand_t mag_a;
  imul_pkg::operand_t mag_b;

  // zero-extended multiplicand for the first step
  imul_pkg::product_t a_init;

  // sum plus the current multiplicand
  imul_pkg::product_t sum_add;

  // product sign differs from magnitude sign
  logic               neg_result;

  // next counter value during a step
  imul_pkg::count_t   count_dec;

  assign mag_a = req_a[imul_pkg::DATA_W-1] ? imul_pkg::operand_t'(-req_a) : req_a;
  assign mag_b = req_b[imul_pkg::DATA_W-1] ? imul_pkg::operand_t'(-req_b) : req_b;

  assign a_init = {{(imul_pkg::PROD_W - imul_pkg::DATA_W){1'b0}}, mag_a};

  assign sum_add = sum_reg + a_reg;

  assign neg_result = sign_a_reg ^ sign_b_reg;

  // hold at zero on the final step instead of wrapping back to 31
  assign count_dec = count_zero ? count_reg : count_reg - imul_pkg::count_t'(1);

  assign count_zero = (count_reg == '0);

  // partial sum goes straight out, stable while control sits in done
  assign resp_result = sum_reg;

  // --------------------------------------------------
  // iteration counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count_reg <= '0;
    end else if (load) begin
      // 32 steps follow, the last one runs with the counter at zero
      count_reg <= imul_pkg::count_t'(imul_pkg::DATA_W - 1);
    end else if (step) begin
      count_reg <= count_dec;
    end
  end

  // --------------------------------------------------
  // operand shift registers and sign capture
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      a_reg      <= a_init;
      b_reg      <= mag_b;
      sign_a_reg <= req_a[imul_pkg::DATA_W-1];
      sign_b_reg <= req_b[imul_pkg::DATA_W-1];
    end else if (step) begin
      // multiplicand doubles, multiplier exposes its next bit
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // --------------------------------------------------
  // partial sum
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      sum_reg <= '0;
    end else if (step) begin
      // add only when the current multiplier bit is set
      if (b_reg[0]) begin
        sum_reg <= sum_add;
      end
    end else if (fix_sign) begin
      // exactly one negative operand gives a negative product
      if (neg_result) begin
        sum_reg <= imul_pkg::product_t'(-sum_reg);
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // the step taken at zero is the last one, control leaves calc with it
  // and the counter stays at zero instead of wrapping
  a_last_step_no_wrap: assert property (
    @(posedge clk) disable iff (reset)
    (step && count_zero) |=> (!step && count_zero)
  ) else $error("step issued again after the final iteration");

  // a new request must never overlap a running multiplication
  a_no_load_during_step: assert property (
    @(posedge clk) disable iff (reset)
    !(load && step)
  ) else $error("load and step asserted in the same cycle");

endmodule

// ==== src/imul_pkg.sv ====
/*
  shared widths, vector typedefs and control state encoding
  for the iterative signed multiplier
*/

package imul_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // one request operand, two's complement
  localparam int DATA_W = 32;

  // full signed product
  localparam int PROD_W = 64;

  // iteration counter covers DATA_W steps, 31 down to 0
  localparam int CNT_W = $clog2(DATA_W);

  // --------------------------------------------------
  // vector types
  // --------------------------------------------------

  typedef logic [DATA_W-1:0] operand_t;

  // product, shifted multiplicand and partial sum share this width
  typedef logic [PROD_W-1:0] product_t;

  typedef logic [CNT_W-1:0]  count_t;

  // --------------------------------------------------
  // control FSM states
  // --------------------------------------------------

  // st_idle  waiting for a request, req_rdy high
  // st_calc  one shift-and-add step per cycle
  // st_sign  single cycle of product negation
  // st_done  response valid, held until taken
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_sign = 2'd2,
    st_done = 2'd3
  } mul_state_e;

endpackage

// ==== testbench/tb_imul_iter.sv ====
/*
  directed testbench for the iterative signed multiplier:
  reset, operand corners, random pairs, back-pressure, latency
*/

`timescale 1ns/1ns

module tb_imul_iter;

  localparam int          TIMEOUT_CYCLES = 100;
  localparam logic [31:0] RAND_SEED      = 32'hbad7_2573;
  // accept edge to first resp_val covers the shift-and-add steps plus the sign cycle
  localparam int          LATENCY        = 33;

  logic               clk = 1'b0;
  logic               reset;
  imul_pkg::operand_t req_a;
  imul_pkg::operand_t req_b;
  logic               req_val;
  logic               req_rdy;
  imul_pkg::product_t resp_result;
  logic               resp_val;
  logic               resp_rdy;

  int check_errors = 0;
  int pass_tests   = 0;
  int fail_tests   = 0;

  // 40 ns period
  always #20 clk = ~clk;

  imul_iter u_imul_iter (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // --------------------------------------------------
  // reference model and checks
  // --------------------------------------------------

  // exact signed product of any 32-bit pair fits in 64 bits
  function automatic imul_pkg::product_t ref_product(input imul_pkg::operand_t a,
                                                     input imul_pkg::operand_t b);
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    return imul_pkg::product_t'(sa * sb);
  endfunction

  task automatic check_product(input string test, input imul_pkg::operand_t a,
                               input imul_pkg::operand_t b, input imul_pkg::product_t actual);
    imul_pkg::product_t expected;
    expected = ref_product(a, b);
    assert (actual === expected) else begin
      $display("** Error %s: %h * %h expected %h, actual %h", test, a, b, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_flag(input string test, input string what,
                            input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("** Error %s: %s expected %b, actual %b", test, what, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_count(input string test, input string what,
                             input int expected, input int actual);
    assert (actual == expected) else begin
      $display("** Error %s: %s expected %0d, actual %0d", test, what, expected, actual);
      check_errors++;
    end
  endtask

  // handshake rule gathered over several cycles by the caller
  task automatic check_true(input string test, input bit cond, input string msg);
    assert (cond) else begin
      $display("Error in %s: %s", test, msg);
      check_errors++;
    end
  endtask

  // --------------------------------------------------
  // run control and reporting
  // --------------------------------------------------

  task automatic finish_run();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             pass_tests, fail_tests, check_errors);
    if (fail_tests == 0 && check_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
    check_errors++;
    finish_run();
  endtask

  task automatic report_test(input string test, input int errs_before);
    if (check_errors == errs_before) begin
      pass_tests++;
      $display("test %s finished, passed", test);
    end else begin
      fail_tests++;
      $display("test %s finished, %0d errors", test, check_errors - errs_before);
    end
  endtask

  // --------------------------------------------------
  // request and response handshakes
  // --------------------------------------------------

  // returns right on the accept edge
  // bp keeps resp_rdy low and req_val high until the response is taken
  task automatic send_req(input imul_pkg::operand_t a, input imul_pkg::operand_t b,
                          input bit bp);
    int n;
    @(posedge clk);
    req_a    <= a;
    req_b    <= b;
    req_val  <= 1'b1;
    resp_rdy <= !bp;
    n = 0;
    // req_rdy seen at a falling edge holds through the next rising edge
    do begin
      @(negedge clk);
      n++;
    end while (!req_rdy && n < TIMEOUT_CYCLES);
    if (!req_rdy) timeout_abort("request accept");
    @(posedge clk);
    if (!bp) req_val <= 1'b0;
  endtask

  // latency counts rising edges after the accept edge
  // with bp set resp_rdy stays low for hold cycles past the first
  task automatic recv_resp(input bit bp, input int hold, output imul_pkg::product_t res,
                           output int latency, output bit busy_ok, output bit stable_ok,
                           output bit idle_ok);
    int n;
    busy_ok   = 1'b1;
    stable_ok = 1'b1;
    idle_ok   = 1'b1;
    res       = '0;
    // first falling edge follows the accept edge itself
    latency   = -1;
    do begin
      @(negedge clk);
      latency++;
      if (req_rdy) busy_ok = 1'b0;
    end while (!resp_val && latency < TIMEOUT_CYCLES);
    if (!resp_val) timeout_abort("response valid");
    res = resp_result;
    if (bp) begin
      for (n = 0; n < hold; n++) begin
        @(negedge clk);
        if (!resp_val || req_rdy || resp_result !== res) stable_ok = 1'b0;
      end
      // release back-pressure while the extra request stays up through the hand-off
      @(posedge clk);
      resp_rdy <= 1'b1;
      @(negedge clk);
      if (!resp_val || req_rdy || resp_result !== res) stable_ok = 1'b0;
    end
    // hand-off edge and idle one cycle later
    @(posedge clk);
    req_val <= 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) idle_ok = 1'b0;
  endtask

  // one multiplication with resp_rdy high and its product and return to idle checked
  task automatic run_pair(input string test, input imul_pkg::operand_t a,
                          input imul_pkg::operand_t b);
    imul_pkg::product_t res;
    int                 lat;
    bit                 busy_ok;
    bit                 stable_ok;
    bit                 idle_ok;
    send_req(a, b, 1'b0);
    recv_resp(1'b0, 0, res, lat, busy_ok, stable_ok, idle_ok);
    check_product(test, a, b, res);
    check_true(test, idle_ok, "unit did not return to idle after the response was taken");
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic test_reset();
    int errs_before;
    errs_before = check_errors;
    @(negedge clk);
    check_flag("reset", "req_rdy", 1'b1, req_rdy);
    check_flag("reset", "resp_val", 1'b0, resp_val);
    report_test("reset", errs_before);
  endtask

  task automatic test_nonneg();
    imul_pkg::operand_t pa[7];
    imul_pkg::operand_t pb[7];
    int                 errs_before;
    errs_before = check_errors;
    pa = '{32'd0, 32'd0, 32'd7, 32'd1, 32'h7fff_ffff, 32'h0001_0000, 32'd12345};
    pb = '{32'd0, 32'd5, 32'd6, 32'h7fff_ffff, 32'h7fff_ffff, 32'h0001_0000, 32'd6789};
    for (int i = 0; i < 7; i++) begin
      run_pair("nonneg", pa[i], pb[i]);
    end
    report_test("nonneg", errs_before);
  endtask

  task automatic test_signed();
    imul_pkg::operand_t pa[10];
    imul_pkg::operand_t pb[10];
    int                 errs_before;
    errs_before = check_errors;
    // -1*-1, min*min, min*1, min*-1, 0*neg, then mixed signs
    pa = '{32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'd0,
           32'hffff_fffd, 32'd3, 32'hffff_fff9, 32'd1, 32'h7fff_ffff};
    pb = '{32'hffff_ffff, 32'h8000_0000, 32'd1, 32'hffff_ffff, 32'hffff_fffb,
           32'd7, 32'hffff_fff9, 32'hffff_fffd, 32'h8000_0000, 32'h8000_0000};
    for (int i = 0; i < 10; i++) begin
      run_pair("signed", pa[i], pb[i]);
    end
    report_test("signed", errs_before);
  endtask

  task automatic test_random();
    int errs_before;
    errs_before = check_errors;
    for (int i = 0; i < 200; i++) begin
      run_pair("random", $urandom, $urandom);
    end
    report_test("random", errs_before);
  endtask

  task automatic test_backpressure();
    imul_pkg::operand_t a;
    imul_pkg::operand_t b;
    imul_pkg::product_t res;
    int                 hold;
    int                 lat;
    bit                 busy_ok;
    bit                 stable_ok;
    bit                 idle_ok;
    int                 errs_before;
    errs_before = check_errors;
    for (int i = 0; i < 12; i++) begin
      a    = $urandom;
      b    = $urandom;
      hold = $urandom_range(20, 0);
      send_req(a, b, 1'b1);
      recv_resp(1'b1, hold, res, lat, busy_ok, stable_ok, idle_ok);
      check_product("backpressure", a, b, res);
      check_true("backpressure", stable_ok, "response changed or req_rdy rose while stalled");
      check_true("backpressure", busy_ok, "req_rdy rose during the multiplication");
      check_true("backpressure", idle_ok, "held req_val started a second multiplication");
    end
    report_test("backpressure", errs_before);
  endtask

  task automatic test_latency();
    imul_pkg::operand_t pa[4];
    imul_pkg::operand_t pb[4];
    imul_pkg::product_t res;
    int                 lat;
    bit                 busy_ok;
    bit                 stable_ok;
    bit                 idle_ok;
    int                 errs_before;
    errs_before = check_errors;
    pa = '{32'd0, 32'hffff_ffff, 32'h8000_0000, 32'd99};
    pb = '{32'd0, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ff00};
    for (int i = 0; i < 4; i++) begin
      send_req(pa[i], pb[i], 1'b0);
      recv_resp(1'b0, 0, res, lat, busy_ok, stable_ok, idle_ok);
      check_count("latency", "cycles to resp_val", LATENCY, lat);
      check_true("latency", busy_ok, "req_rdy rose before the response was taken");
      check_product("latency", pa[i], pb[i], res);
    end
    report_test("latency", errs_before);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(RAND_SEED));
    reset    <= 1'b1;
    req_a    <= '0;
    req_b    <= '0;
    req_val  <= 1'b0;
    resp_rdy <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_reset();
    test_nonneg();
    test_signed();
    test_random();
    test_backpressure();
    test_latency();
    finish_run();
  end

endmodule

// ==== vlog.f ====
src/imul_pkg.sv
src/imul_iter_dpath.sv
src/imul_iter_ctrl.sv
src/imul_iter.sv
testbench/tb_imul_iter.sv
